//--- design/dtim_pkg.sv
`default_nettype none

package dtim_pkg;

  //////////////////////////////////////////////////
  // Bus types

  typedef logic [31:0] word_t;    // Data word
  typedef logic [31:0] addr_t;    // Byte address
  typedef logic [3:0]  strb_t;    // Byte strobes, nonzero means store

  //////////////////////////////////////////////////
  // Default geometry

  localparam int DTIM_DEPTH = 4;  // Index bits
  localparam int DTIM_WIDTH = 2;  // Log2 of words per line

  localparam addr_t DTIM_BASE = 32'h0000_1000;  // First address served
  localparam addr_t DTIM_TOP  = 32'h0000_2000;  // First address past the window

  //////////////////////////////////////////////////
  // Controller FSM

  typedef enum logic [2:0] {
    LOOKUP,   // Idle, classifies the front request
    FILL,     // Line fetch from backing memory
    BYPASS,   // Single word access to backing memory
    UPDATE,   // Answer after a line write
    FENCE     // Lock sweep over all indices
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/dtim_ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dtim_ram_if #(
  parameter int DEPTH = dtim_pkg::DTIM_DEPTH,
  parameter int W = 1
);

  logic             wen;
  logic [DEPTH-1:0] waddr;
  logic [DEPTH-1:0] raddr;
  logic [W-1:0]     wdata;
  logic [W-1:0]     rdata;  // Registered, one cycle after raddr

  modport ctrl (
    output wen, waddr, raddr, wdata,
    input  rdata
  );

  modport array (
    input  wen, waddr, raddr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- design/dtim_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dtim_ram #(
  parameter int DEPTH = dtim_pkg::DTIM_DEPTH,
  parameter int W = 1
) (
  input logic       clk,
  dtim_ram_if.array bus
);

  logic [W-1:0] mem [0:2**DEPTH-1] = '{default: '0};
  logic [W-1:0] rdata_q = '0;

  assign bus.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (bus.wen) begin
      mem[bus.waddr] <= bus.wdata;
    end
    rdata_q <= mem[bus.raddr];  // Old data on a same-cycle write
  end

  // Write index comes from the controller's front register
  a_waddr_known: assert property (
    @(posedge clk) bus.wen |-> !$isunknown(bus.waddr)
  );

endmodule

`default_nettype wire

//--- design/dtim_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dtim_ctrl #(
  parameter int DEPTH = dtim_pkg::DTIM_DEPTH,
  parameter int WIDTH = dtim_pkg::DTIM_WIDTH,
  parameter dtim_pkg::addr_t BASE_ADDR = dtim_pkg::DTIM_BASE,
  parameter dtim_pkg::addr_t TOP_ADDR = dtim_pkg::DTIM_TOP
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_valid,
  input  logic            req_fence,
  input  dtim_pkg::addr_t req_addr,
  input  dtim_pkg::word_t req_wdata,
  input  dtim_pkg::strb_t req_wstrb,
  output logic            resp_ready,
  output dtim_pkg::word_t resp_rdata,
  output logic            mem_valid,
  output dtim_pkg::addr_t mem_addr,
  output dtim_pkg::word_t mem_wdata,
  output dtim_pkg::strb_t mem_wstrb,
  input  logic            mem_ready,
  input  dtim_pkg::word_t mem_rdata,
  dtim_ram_if.ctrl        tag_bus,
  dtim_ram_if.ctrl        line_bus,
  dtim_ram_if.ctrl        lock_bus
);

  localparam int TAG_W   = 30 - DEPTH - WIDTH;
  localparam int WORDS   = 2 ** WIDTH;
  localparam int IDX_LSB = WIDTH + 2;
  localparam int TAG_LSB = DEPTH + WIDTH + 2;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [DEPTH-1:0] idx_t;
  typedef logic [WIDTH-1:0] off_t;
  typedef dtim_pkg::word_t [WORDS-1:0] line_t;

  // Front register, holds the request until it is answered
  logic            f_valid;
  logic            f_fence;
  dtim_pkg::addr_t f_addr;
  tag_t            f_tag;
  idx_t            f_idx;
  off_t            f_off;
  dtim_pkg::word_t f_wdata;
  dtim_pkg::strb_t f_wstrb;
  logic            f_store;

  dtim_pkg::ctrl_state_e state;
  dtim_pkg::ctrl_state_e state_next;
  off_t  cnt;     // Fill beat
  idx_t  sweep;   // Fence index
  line_t line_q;  // Fill buffer and last written line
  line_t line_rd;
  line_t fill_line;
  line_t line_wdata;
  idx_t  rd_idx;
  logic  in_window;
  logic  locked;
  logic  tag_match;
  logic  go_fill;
  logic  go_bypass;
  logic  bypass_path;
  logic  line_wen;

  function automatic line_t merge_word(line_t line, off_t off, dtim_pkg::word_t wdata,
                                       dtim_pkg::strb_t strb);
    line_t res;
    res = line;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[off][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Front

  always_ff @(posedge clk) begin
    if (!rst) begin
      f_valid <= 1'b0;
      f_fence <= 1'b0;
    end else begin
      f_valid <= req_valid;
      f_fence <= req_valid & req_fence;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      f_addr  <= req_addr;
      f_tag   <= req_addr[31:TAG_LSB];
      f_idx   <= req_addr[TAG_LSB-1:IDX_LSB];
      f_off   <= req_addr[IDX_LSB-1:2];
      f_wdata <= req_wdata;
      f_wstrb <= req_wstrb;
    end
  end

  assign f_store = |f_wstrb;
  assign rd_idx  = req_valid ? req_addr[TAG_LSB-1:IDX_LSB] : f_idx;  // Data lines up next cycle

  assign tag_bus.raddr  = rd_idx;
  assign line_bus.raddr = rd_idx;
  assign lock_bus.raddr = rd_idx;

  //////////////////////////////////////////////////
  // Back FSM

  assign line_rd   = line_bus.rdata;
  assign in_window = (f_addr >= BASE_ADDR) && (f_addr < TOP_ADDR);
  assign locked    = lock_bus.rdata[0];
  assign tag_match = (tag_bus.rdata == f_tag);

  always_comb begin
    fill_line      = line_q;
    fill_line[cnt] = mem_rdata;  // Incoming beat
  end

  // Loads carry zero strobes and pass through unchanged
  assign line_wdata = merge_word((state == dtim_pkg::FILL) ? fill_line : line_rd,
                                 f_off, f_wdata, f_wstrb);

  always_comb begin
    state_next = state;
    go_fill    = 1'b0;
    go_bypass  = 1'b0;
    line_wen   = 1'b0;
    resp_ready = 1'b0;
    resp_rdata = '0;
    case (state)
      dtim_pkg::LOOKUP: begin
        if (f_valid) begin
          if (f_fence) begin
            state_next = dtim_pkg::FENCE;
          end else if (!in_window || (locked && !tag_match)) begin
            go_bypass  = 1'b1;
            state_next = dtim_pkg::BYPASS;
          end else if (!locked) begin
            go_fill    = 1'b1;  // First touch claims the index
            state_next = dtim_pkg::FILL;
          end else if (f_store) begin
            line_wen   = 1'b1;
            state_next = dtim_pkg::UPDATE;
          end else begin
            resp_ready = 1'b1;
            resp_rdata = line_rd[f_off];
          end
        end
      end
      dtim_pkg::FILL: begin
        if (mem_ready && cnt == '1) begin
          line_wen   = 1'b1;  // Store miss merges here
          state_next = dtim_pkg::UPDATE;
        end
      end
      dtim_pkg::BYPASS: begin
        resp_ready = mem_ready;
        resp_rdata = f_store ? '0 : mem_rdata;
        if (mem_ready) begin
          state_next = dtim_pkg::LOOKUP;
        end
      end
      dtim_pkg::UPDATE: begin
        resp_ready = 1'b1;
        resp_rdata = f_store ? '0 : line_q[f_off];
        state_next = dtim_pkg::LOOKUP;
      end
      dtim_pkg::FENCE: begin
        if (sweep == '1) begin
          resp_ready = 1'b1;
          state_next = dtim_pkg::LOOKUP;
        end
      end
      default: begin
        state_next = dtim_pkg::LOOKUP;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= dtim_pkg::LOOKUP;
      cnt   <= '0;
      sweep <= '0;
    end else begin
      state <= state_next;
      if (state == dtim_pkg::FILL && mem_ready) begin
        cnt <= cnt + off_t'(1);  // Wraps back to zero after the last beat
      end
      if (state == dtim_pkg::FENCE) begin
        sweep <= sweep + idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_wen) begin
      line_q <= line_wdata;
    end else if (state == dtim_pkg::FILL && mem_ready) begin
      line_q <= fill_line;
    end
  end

  //////////////////////////////////////////////////
  // Array writes and memory side

  assign tag_bus.wen    = line_wen;
  assign tag_bus.waddr  = f_idx;
  assign tag_bus.wdata  = f_tag;
  assign line_bus.wen   = line_wen;
  assign line_bus.waddr = f_idx;
  assign line_bus.wdata = line_wdata;
  assign lock_bus.wen   = line_wen | (state == dtim_pkg::FENCE);
  assign lock_bus.waddr = (state == dtim_pkg::FENCE) ? sweep : f_idx;
  assign lock_bus.wdata = (state == dtim_pkg::FENCE) ? 1'b0 : 1'b1;

  assign bypass_path = go_bypass | (state == dtim_pkg::BYPASS);

  assign mem_valid = go_fill | bypass_path | (state == dtim_pkg::FILL);
  assign mem_addr  = bypass_path ? f_addr : {f_tag, f_idx, cnt, 2'b00};
  assign mem_wdata = f_wdata;
  assign mem_wstrb = bypass_path ? f_wstrb : '0;

  a_mem_addr_stable: assert property (
    @(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |=> $stable(mem_addr)
  );

  a_resp_pulse: assert property (
    @(posedge clk) disable iff (!rst)
    resp_ready |=> !resp_ready
  );

endmodule

`default_nettype wire

//--- design/dtim.sv
`timescale 1ns/1ps
`default_nettype none

module dtim #(
  parameter int DEPTH = dtim_pkg::DTIM_DEPTH,
  parameter int WIDTH = dtim_pkg::DTIM_WIDTH,
  parameter dtim_pkg::addr_t BASE_ADDR = dtim_pkg::DTIM_BASE,
  parameter dtim_pkg::addr_t TOP_ADDR = dtim_pkg::DTIM_TOP
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_valid,
  input  logic            req_fence,
  input  dtim_pkg::addr_t req_addr,
  input  dtim_pkg::word_t req_wdata,
  input  dtim_pkg::strb_t req_wstrb,
  output logic            resp_ready,
  output dtim_pkg::word_t resp_rdata,
  output logic            mem_valid,
  output dtim_pkg::addr_t mem_addr,
  output dtim_pkg::word_t mem_wdata,
  output dtim_pkg::strb_t mem_wstrb,
  input  logic            mem_ready,
  input  dtim_pkg::word_t mem_rdata
);

  localparam int TAG_W  = 30 - DEPTH - WIDTH;
  localparam int LINE_W = 32 * (2 ** WIDTH);

  dtim_ram_if #(.DEPTH(DEPTH), .W(TAG_W))  tag_bus ();
  dtim_ram_if #(.DEPTH(DEPTH), .W(LINE_W)) line_bus ();
  dtim_ram_if #(.DEPTH(DEPTH), .W(1))      lock_bus ();  // Claimed index flags

  dtim_ram #(.DEPTH(DEPTH), .W(TAG_W)) u_tag_ram (
    .clk (clk),
    .bus (tag_bus)
  );

  dtim_ram #(.DEPTH(DEPTH), .W(LINE_W)) u_line_ram (
    .clk (clk),
    .bus (line_bus)
  );

  dtim_ram #(.DEPTH(DEPTH), .W(1)) u_lock_ram (
    .clk (clk),
    .bus (lock_bus)
  );

  dtim_ctrl #(
    .DEPTH     (DEPTH),
    .WIDTH     (WIDTH),
    .BASE_ADDR (BASE_ADDR),
    .TOP_ADDR  (TOP_ADDR)
  ) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_fence  (req_fence),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .tag_bus    (tag_bus),
    .line_bus   (line_bus),
    .lock_bus   (lock_bus)
  );

endmodule

`default_nettype wire

//--- verification/dtim_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dtim_checker (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_valid,
  input  dtim_pkg::word_t exp_rdata,
  input  logic            resp_ready,
  input  dtim_pkg::word_t resp_rdata,
  input  logic            mem_valid,
  output int              responses,
  output int              mismatches,
  output int              protocol_errors
);

  dtim_pkg::word_t exp_q [$];  // One entry per outstanding request
  int   resp_cnt = 0;
  int   mismatch_cnt = 0;
  int   proto_cnt = 0;
  logic reset_seen = 1'b0;
  logic req_seen = 1'b0;

  assign responses       = resp_cnt;
  assign mismatches      = mismatch_cnt;
  assign protocol_errors = proto_cnt;

  always @(posedge clk) begin
    dtim_pkg::word_t expected;
    if (reset_seen && !req_seen && (resp_ready !== 1'b0 || mem_valid !== 1'b0)) begin
      $display("resp_ready or mem_valid not low after reset at %0t", $time);
      proto_cnt = proto_cnt + 1;
    end
    if (resp_ready === 1'b1) begin
      resp_cnt = resp_cnt + 1;
      if (exp_q.size() == 0) begin
        $display("Extra response at %0t with no request outstanding", $time);
        proto_cnt = proto_cnt + 1;
      end else begin
        expected = exp_q.pop_front();
        if (resp_rdata !== expected) begin
          $display("FAILED at %0t: resp_rdata %h, expected %h", $time, resp_rdata, expected);
          mismatch_cnt = mismatch_cnt + 1;
        end
      end
    end
    if (!rst) begin
      reset_seen <= 1'b1;
    end
    if (req_valid === 1'b1) begin
      req_seen <= 1'b1;
      exp_q.push_back(exp_rdata);  // Response comes one cycle later at the earliest
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_dtim.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dtim;

  localparam int DEPTH = dtim_pkg::DTIM_DEPTH;
  localparam int WIDTH = dtim_pkg::DTIM_WIDTH;
  localparam int CYCLES_PER_REQ = 2**DEPTH + 4 * 2**WIDTH + 10;

  logic            clk = 1'b0;
  logic            rst;
  logic            req_valid;
  logic            req_fence;
  dtim_pkg::addr_t req_addr;
  dtim_pkg::word_t req_wdata;
  dtim_pkg::strb_t req_wstrb;
  logic            resp_ready;
  dtim_pkg::word_t resp_rdata;
  logic            mem_valid;
  dtim_pkg::addr_t mem_addr;
  dtim_pkg::word_t mem_wdata;
  dtim_pkg::strb_t mem_wstrb;
  logic            mem_ready = 1'b0;
  dtim_pkg::word_t mem_rdata = '0;
  dtim_pkg::word_t exp_rdata;
  int              responses;
  int              mismatches;
  int              protocol_errors;
  int              n_req = 0;

  logic [3:0]      op_q [$];
  dtim_pkg::addr_t addr_q [$];
  dtim_pkg::word_t wdata_q [$];
  dtim_pkg::strb_t strb_q [$];
  dtim_pkg::word_t expect_q [$];

  dtim_pkg::word_t backing [dtim_pkg::addr_t];  // Written words only
  int unsigned     rng = 32'd67;
  int unsigned     delay = 0;
  logic            busy = 1'b0;

  always #20 clk = ~clk;

  dtim #(.DEPTH(DEPTH), .WIDTH(WIDTH)) u_dtim (
    .clk (clk), .rst (rst),
    .req_valid (req_valid), .req_fence (req_fence), .req_addr (req_addr),
    .req_wdata (req_wdata), .req_wstrb (req_wstrb),
    .resp_ready (resp_ready), .resp_rdata (resp_rdata),
    .mem_valid (mem_valid), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb), .mem_ready (mem_ready), .mem_rdata (mem_rdata)
  );

  dtim_checker u_checker (
    .clk (clk), .rst (rst), .req_valid (req_valid), .exp_rdata (exp_rdata),
    .resp_ready (resp_ready), .resp_rdata (resp_rdata), .mem_valid (mem_valid),
    .responses (responses), .mismatches (mismatches), .protocol_errors (protocol_errors)
  );

  //////////////////////////////////////////////////
  // Backing memory

  function automatic int unsigned xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic dtim_pkg::word_t read_word(dtim_pkg::addr_t a);
    dtim_pkg::addr_t wa;
    wa = {a[31:2], 2'b00};
    if (backing.exists(wa)) begin
      return backing[wa];
    end
    return wa ^ 32'hA5A5_0000;  // Unwritten pattern
  endfunction

  function automatic void write_word(dtim_pkg::addr_t a, dtim_pkg::word_t d,
                                     dtim_pkg::strb_t s);
    dtim_pkg::word_t w;
    w = read_word(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    backing[{a[31:2], 2'b00}] = w;
  endfunction

  always @(negedge clk) begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    if (rst && mem_valid) begin
      if (!busy) begin
        busy  = 1'b1;  // First cycle of a beat
        delay = xorshift() % 3;
      end else if (delay == 0) begin
        busy      = 1'b0;
        mem_ready = 1'b1;
        if (mem_wstrb != '0) begin
          write_word(mem_addr, mem_wdata, mem_wstrb);
        end else begin
          mem_rdata = read_word(mem_addr);
        end
      end else begin
        delay = delay - 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  task automatic load_requests();
    int              fd;
    string           text;
    logic [3:0]      op;
    dtim_pkg::addr_t addr;
    dtim_pkg::word_t wdata;
    dtim_pkg::strb_t strb;
    dtim_pkg::word_t expected;
    fd = $fopen("verification/dtim_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verification/dtim_golden.txt");
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(text, fd) != 0 &&
          $sscanf(text, "%h %h %h %h %h", op, addr, wdata, strb, expected) == 5) begin
        op_q.push_back(op);
        addr_q.push_back(addr);
        wdata_q.push_back(wdata);
        strb_q.push_back(strb);
        expect_q.push_back(expected);
      end
    end
    $fclose(fd);
  endtask

  task automatic issue_request(int i);
    @(negedge clk);
    req_valid = 1'b1;
    req_fence = (op_q[i] == 4'h2);
    req_addr  = addr_q[i];
    req_wdata = wdata_q[i];
    req_wstrb = strb_q[i];
    exp_rdata = expect_q[i];
    @(negedge clk);
    req_valid = 1'b0;
    req_fence = 1'b0;
    wait (responses > i);
  endtask

  initial begin
    int missing;
    rst       = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_wstrb = '0;
    exp_rdata = '0;
    load_requests();
    n_req = op_q.size();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < n_req; i++) begin
      issue_request(i);
    end
    repeat (4) @(negedge clk);
    missing = n_req - responses;
    if (n_req == 0) begin
      $display("No requests read from the golden file");
    end
    if (missing > 0) begin
      $display("%0d responses missing", missing);
    end
    $display("Requests %0d, mismatches %0d, protocol errors %0d, missing %0d",
             n_req, mismatches, protocol_errors, missing);
    if (n_req > 0 && mismatches == 0 && protocol_errors == 0 && missing <= 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    wait (n_req > 0);
    repeat (n_req * CYCLES_PER_REQ) @(posedge clk);
    $display("Timeout with %0d of %0d responses received", responses, n_req);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
design/dtim_pkg.sv
design/dtim_ram_if.sv
design/dtim_ram.sv
design/dtim_ctrl.sv
design/dtim.sv
verification/dtim_checker.sv
verification/tb_dtim.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_dtim -o sim_dtim

out=$(./obj_dir/sim_dtim)
echo "$out"

echo "$out" | grep -qx "NO ERRORS"

//--- verification/dtim_golden.txt
// op (0 load, 1 store, 2 fence)  address  write data  strobe  expected read data
// Hex columns, geometry of 16 indices with 4 words per line, window 0x1000 to 0x2000
0 00001010 00000000 0 a5a51010
0 00001014 00000000 0 a5a51014
1 00001018 11223344 3 00000000
0 00001018 00000000 0 a5a53344
0 00001118 00000000 0 a5a51118
1 0000111c deadbeef c 00000000
0 0000111c 00000000 0 dead111c
1 00003000 cafef00d f 00000000
0 00003000 00000000 0 cafef00d
1 00003004 00000077 1 00000000
0 00003004 00000000 0 a5a53077
2 00000000 00000000 0 00000000
0 00001114 00000000 0 a5a51114
0 0000111c 00000000 0 dead111c
0 00001018 00000000 0 a5a51018
1 00001020 55667788 6 00000000
0 00001020 00000000 0 a5667720
0 0000102c 00000000 0 a5a5102c
0 00001ffc 00000000 0 a5a51ffc
0 00002000 00000000 0 a5a52000
